/* Makefile */
TOP = tb_display

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f flist.f
	@out="$$(obj_dir/V$(TOP) +verilator+error+limit+100)"; echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

lint:
	verilator --lint-only -Wall --top-module display_top board_pkg.sv por_reset.sv \
		button_sync.sv display_source.sv word_fifo.sv max7219_shifter.sv display_top.sv

clean:
	rm -rf obj_dir

/* board_pkg.sv */
package board_pkg;

    // MAX7219 command word: 4 unused bits, 4-bit register address, 8 data bits
    localparam int cmd_width = 16;

    // digit registers occupy addresses 1..8, digit 1 is the rightmost
    localparam logic [3:0] reg_digit0       = 4'd1;
    localparam logic [3:0] reg_decode       = 4'd9;
    localparam logic [3:0] reg_intensity    = 4'd10;
    localparam logic [3:0] reg_scan_limit   = 4'd11;
    localparam logic [3:0] reg_shutdown     = 4'd12;
    localparam logic [3:0] reg_display_test = 4'd15;

    // values sent once after reset
    localparam logic [7:0] init_decode       = 8'h00;  // raw segments, no BCD decode
    localparam logic [7:0] init_intensity    = 8'h07;
    localparam logic [7:0] init_scan_limit   = 8'h07;  // scan all eight digits
    localparam logic [7:0] init_shutdown     = 8'h01;  // normal operation
    localparam logic [7:0] init_display_test = 8'h00;

    localparam int init_words = 5;

    // hex font, bit 7 = DP, bits 6..0 = segments A..G
    // entry 0 is the rightmost element of the concatenation
    localparam logic [15:0][7:0] seg_font = {
        8'h47, 8'h4f, 8'h3d, 8'h4e,  // F E d C
        8'h1f, 8'h77, 8'h7b, 8'h7f,  // b A 9 8
        8'h70, 8'h5f, 8'h5b, 8'h33,  // 7 6 5 4
        8'h79, 8'h6d, 8'h30, 8'h7e   // 3 2 1 0
    };

    function automatic logic [cmd_width-1:0] cmd_word(input logic [3:0] addr,
                                                      input logic [7:0] data);
        return {4'b0000, addr, data};
    endfunction

endpackage

/* button_sync.sv */
`timescale 1ns/10ps

module button_sync #(
    parameter int debounce_cycles = 200000
) (
    input  logic clk,
    input  logic reset,
    input  logic btnl,
    input  logic btnr,
    output logic inc,
    output logic dec
);

    localparam int cw = (debounce_cycles > 1) ? $clog2(debounce_cycles) : 1;
    localparam logic [cw-1:0] last_cnt = cw'(debounce_cycles - 1);

    logic [1:0]    raw;
    logic [1:0]    sync1;
    logic [1:0]    sync2;
    logic [1:0]    level;       // debounced
    logic [1:0]    press;
    logic [cw-1:0] stable_cnt [2];

    assign raw = {btnr, btnl};

    // per button: sync, count how long the raw level differs, then follow it
    always_ff @(posedge clk) begin
        if (reset) begin
            sync1      <= '0;
            sync2      <= '0;
            level      <= '0;
            press      <= '0;
            stable_cnt <= '{default: '0};
        end else begin
            sync1 <= raw;
            sync2 <= sync1;
            for (int i = 0; i < 2; i++) begin
                press[i] <= 1'b0;
                if (sync2[i] == level[i]) begin
                    stable_cnt[i] <= '0;  // glitch or idle, start over
                end else if (stable_cnt[i] == last_cnt) begin
                    stable_cnt[i] <= '0;
                    level[i]      <= sync2[i];
                    press[i]      <= sync2[i];  // rising edge only
                end else begin
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
                end
            end
        end
    end

    // left button counts up, right button counts down
    assign inc = press[0];
    assign dec = press[1];

endmodule

/* display_chk.sv */
`timescale 1ns/10ps

module display_chk (
    input logic clk,
    input logic sys_reset,
    input logic wr_en,
    input logic full,
    input logic rd_en,
    input logic empty,
    input logic max7219_clk,
    input logic max7219_data,
    input logic max7219_load
);

    int fail_count = 0;

    no_write_full: assert property (@(posedge clk) disable iff (sys_reset) !(wr_en && full))
        else begin
            $error("fifo written while full");
            fail_count++;
        end

    no_read_empty: assert property (@(posedge clk) disable iff (sys_reset) !(rd_en && empty))
        else begin
            $error("fifo read while empty");
            fail_count++;
        end

    // latch pulse only between frames
    load_clk_low: assert property (@(posedge clk) disable iff (sys_reset)
                                   !(max7219_load && max7219_clk))
        else begin
            $error("load high while serial clock high");
            fail_count++;
        end

    data_stable: assert property (@(posedge clk) disable iff (sys_reset)
                                  max7219_clk && $past(max7219_clk) |-> $stable(max7219_data))
        else begin
            $error("serial data moved while serial clock high");
            fail_count++;
        end

endmodule

// the fifo and shifter ports meet as wires in the top level
bind display_top display_chk chk_i (
    .clk         (clk),
    .sys_reset   (sys_reset),
    .wr_en       (wr_en),
    .full        (full),
    .rd_en       (rd_en),
    .empty       (empty),
    .max7219_clk (max7219_clk),
    .max7219_data(max7219_data),
    .max7219_load(max7219_load)
);

/* display_source.sv */
`timescale 1ns/10ps

module display_source import board_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 inc,
    input  logic                 dec,
    input  logic                 full,
    output logic                 wr_en,
    output logic [cmd_width-1:0] wr_data,
    output logic [5:0]           led
);

    localparam logic [3:0] first_digit = 4'(init_words);
    localparam logic [3:0] last_idx    = 4'(init_words + 7);

    logic [31:0] counter;
    logic [31:0] snap;          // value being shown by the current sequence
    logic        dirty;
    logic        init_pending;
    logic        busy;
    logic [3:0]  idx;           // 0..4 init words, 5..12 digits
    logic [3:0]  digit;
    logic        change;
    logic        start;

    assign change = inc ^ dec;  // both at once cancel out
    assign start  = !busy && (init_pending || dirty);
    assign wr_en  = busy && !full;

    always_ff @(posedge clk) begin
        if (reset) begin
            counter <= '0;
            led     <= '1;
        end else begin
            if (inc && !dec)
                counter <= counter + 1'b1;
            else if (dec && !inc)
                counter <= counter - 1'b1;
            led <= ~counter[5:0];  // LEDs are active low
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dirty        <= 1'b0;
            init_pending <= 1'b1;
            busy         <= 1'b0;
            idx          <= '0;
            snap         <= '0;
        end else begin
            dirty <= (dirty && !start) || change;  // a press during start stays pending
            if (start) begin
                busy         <= 1'b1;
                init_pending <= 1'b0;
                snap         <= counter;
                idx          <= init_pending ? 4'd0 : first_digit;
            end else if (wr_en) begin
                if (idx == last_idx)
                    busy <= 1'b0;
                else
                    idx <= idx + 1'b1;
            end
        end
    end

    assign digit = idx - first_digit;

    // build the word for the current index
    always_comb begin
        case (idx)
            4'd0:    wr_data = cmd_word(reg_display_test, init_display_test);
            4'd1:    wr_data = cmd_word(reg_decode, init_decode);
            4'd2:    wr_data = cmd_word(reg_intensity, init_intensity);
            4'd3:    wr_data = cmd_word(reg_scan_limit, init_scan_limit);
            4'd4:    wr_data = cmd_word(reg_shutdown, init_shutdown);
            default: wr_data = cmd_word(reg_digit0 + digit,
                                        seg_font[snap[{digit[2:0], 2'b00} +: 4]]);
        endcase
    end

endmodule

/* display_top.sv */
`timescale 1ns/10ps

module display_top import board_pkg::*; #(
    parameter int reset_cycles    = 100,
    parameter int debounce_cycles = 200000,
    parameter int fifo_depth      = 16,
    parameter int clk_div         = 4
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       btnl,
    input  logic       btnr,
    output logic [5:0] led,
    output logic       max7219_clk,
    output logic       max7219_data,
    output logic       max7219_load
);

    logic                 sys_reset;
    logic                 inc;
    logic                 dec;
    logic                 wr_en;
    logic [cmd_width-1:0] wr_data;
    logic                 full;
    logic                 rd_en;
    logic [cmd_width-1:0] rd_data;
    logic                 empty;

    por_reset #(
        .reset_cycles(reset_cycles)
    ) por_reset_i (
        .clk      (clk),
        .reset    (reset),
        .sys_reset(sys_reset)
    );

    button_sync #(
        .debounce_cycles(debounce_cycles)
    ) button_sync_i (
        .clk  (clk),
        .reset(sys_reset),
        .btnl (btnl),
        .btnr (btnr),
        .inc  (inc),
        .dec  (dec)
    );

    display_source display_source_i (
        .clk    (clk),
        .reset  (sys_reset),
        .inc    (inc),
        .dec    (dec),
        .full   (full),
        .wr_en  (wr_en),
        .wr_data(wr_data),
        .led    (led)
    );

    // command words wait here while the serial link is busy
    word_fifo #(
        .fifo_depth(fifo_depth)
    ) word_fifo_i (
        .clk    (clk),
        .reset  (sys_reset),
        .wr_en  (wr_en),
        .wr_data(wr_data),
        .rd_en  (rd_en),
        .rd_data(rd_data),
        .full   (full),
        .empty  (empty)
    );

    max7219_shifter #(
        .clk_div(clk_div)
    ) max7219_shifter_i (
        .clk         (clk),
        .reset       (sys_reset),
        .empty       (empty),
        .rd_en       (rd_en),
        .rd_data     (rd_data),
        .max7219_clk (max7219_clk),
        .max7219_data(max7219_data),
        .max7219_load(max7219_load)
    );

endmodule

/* flist.f */
board_pkg.sv
por_reset.sv
button_sync.sv
display_source.sv
word_fifo.sv
max7219_shifter.sv
display_top.sv
display_chk.sv
tb_display.sv

/* max7219_shifter.sv */
`timescale 1ns/10ps

module max7219_shifter import board_pkg::*; #(
    parameter int clk_div = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 empty,
    output logic                 rd_en,
    input  logic [cmd_width-1:0] rd_data,
    output logic                 max7219_clk,
    output logic                 max7219_data,
    output logic                 max7219_load
);

    localparam int dw = (clk_div > 1) ? $clog2(clk_div) : 1;
    localparam int bw = $clog2(cmd_width);
    localparam logic [dw-1:0] last_div = dw'(clk_div - 1);
    localparam logic [bw-1:0] last_bit = bw'(cmd_width - 1);

    typedef enum logic [1:0] {
        idle,
        shift,
        load
    } state_t;

    state_t               state;
    logic [dw-1:0]        div_cnt;
    logic [bw-1:0]        bit_cnt;
    logic                 high;     // second half of a bit, serial clock up
    logic [cmd_width-1:0] shreg;

    assign rd_en        = (state == idle) && !empty;
    assign max7219_clk  = (state == shift) && high;
    assign max7219_data = (state == shift) && shreg[cmd_width-1];  // MSB first
    assign max7219_load = (state == load);

    // word being sent, its MSB sits on the data pin
    always_ff @(posedge clk) begin
        if (rd_en)
            shreg <= rd_data;
        else if (state == shift && high && div_cnt == last_div)
            shreg <= shreg << 1;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= idle;
            div_cnt <= '0;
            bit_cnt <= '0;
            high    <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    div_cnt <= '0;
                    bit_cnt <= '0;
                    high    <= 1'b0;
                    if (!empty)
                        state <= shift;
                end
                shift: begin
                    if (div_cnt != last_div) begin
                        div_cnt <= div_cnt + 1'b1;
                    end else begin
                        div_cnt <= '0;
                        high    <= !high;
                        if (high) begin  // end of bit, data moves with clock fall
                            if (bit_cnt == last_bit)
                                state <= load;
                            else
                                bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                load: begin
                    if (div_cnt != last_div) begin
                        div_cnt <= div_cnt + 1'b1;
                    end else begin
                        div_cnt <= '0;
                        state   <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

/* por_reset.sv */
`timescale 1ns/10ps

module por_reset #(
    parameter int reset_cycles = 100
) (
    input  logic clk,
    input  logic reset,
    output logic sys_reset
);

    localparam int cw = $clog2(reset_cycles + 1);

    logic [cw-1:0] count;

    // sys_reset drops exactly reset_cycles edges after reset is first seen low
    always_ff @(posedge clk) begin
        if (reset) begin
            count     <= cw'(reset_cycles);
            sys_reset <= 1'b1;
        end else begin
            sys_reset <= (count != '0);
            if (count != '0)
                count <= count - 1'b1;
        end
    end

endmodule

/* tb_display.sv */
`timescale 1ns/10ps

module tb_display import board_pkg::*; ();

    localparam int clk_div      = 2;
    localparam int word_time    = 33 * clk_div + 1;
    localparam int quiet_cycles = 20 * word_time;
    localparam int n_quiet      = 16;  // quiet waits over all tests, rounded up
    localparam int n_press      = 40;  // presses and glitches, each under 64 cycles
    localparam int limit = n_quiet * (13 * word_time + quiet_cycles) + n_press * 64 + 1000;

    logic        clk;
    logic        reset;
    logic        btnl;
    logic        btnr;
    logic [5:0]  led;
    logic        max7219_clk;
    logic        max7219_data;
    logic        max7219_load;
    logic [31:0] lfsr = 32'h60f105e1;
    logic [31:0] model = '0;       // counter as the presses say it should be
    int          cycle = 0;
    int          last_load = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    logic        sclk_q = 1'b0;
    logic        load_q = 1'b0;
    logic [15:0] rx = '0;
    logic [7:0]  shadow [16];      // MAX7219 register file as seen on the pins
    logic [15:0] word_log [$];

    display_top #(
        .reset_cycles   (16),
        .debounce_cycles(8),
        .fifo_depth     (4),
        .clk_div        (clk_div)
    ) dut_i (
        .clk         (clk),
        .reset       (reset),
        .btnl        (btnl),
        .btnr        (btnr),
        .led         (led),
        .max7219_clk (max7219_clk),
        .max7219_data(max7219_data),
        .max7219_load(max7219_load)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // frame decoder, edges of the serial pins found against the system clock
    always @(posedge clk) begin
        cycle  <= cycle + 1;
        sclk_q <= max7219_clk;
        load_q <= max7219_load;
        if (reset) begin
            for (int i = 0; i < 16; i++)
                shadow[i] <= 'x;
        end else begin
            if (max7219_clk && !sclk_q)
                rx <= {rx[14:0], max7219_data};  // MSB arrives first
            if (max7219_load && !load_q) begin
                shadow[rx[11:8]] <= rx[7:0];
                word_log.push_back(rx);
                last_load <= cycle;
            end
        end
    end

    initial begin
        wait (cycle >= limit);
        $display("timeout: display never went quiet within %0d cycles", limit);
        $display("TESTS FAILED");
        $finish;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic int random_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r = (r << 1) | int'(lfsr[0]);
        end
        return r;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // words lo..hi-1 of the sequence after reset, counted from log entry base
    task automatic check_words(input int base, input int lo, input int hi);
        logic [15:0] exp [13];
        exp[0] = {4'h0, reg_display_test, init_display_test};
        exp[1] = {4'h0, reg_decode, init_decode};
        exp[2] = {4'h0, reg_intensity, init_intensity};
        exp[3] = {4'h0, reg_scan_limit, init_scan_limit};
        exp[4] = {4'h0, reg_shutdown, init_shutdown};
        for (int d = 0; d < 8; d++)
            exp[5 + d] = {4'h0, 4'(reg_digit0 + d), seg_font[0]};
        for (int i = lo; i < hi; i++) begin
            assert (base + i < word_log.size()) else begin
                $display("decoded word %0d never arrived", i);
                errors++;
            end
            if (base + i < word_log.size())
                check_val($sformatf("word %0d", i), 32'(word_log[base + i]), 32'(exp[i]));
        end
    endtask

    task automatic check_display(input logic [31:0] value);
        logic [5:0] exp_led;
        exp_led = ~value[5:0];  // active low
        for (int d = 0; d < 8; d++)
            check_val($sformatf("digit %0d", d + 1), 32'(shadow[d + 1]),
                      32'(seg_font[value[4 * d +: 4]]));
        check_val("led", 32'(led), 32'(exp_led));
    endtask

    task automatic check_checker();
        assert (dut_i.chk_i.fail_count == 0) else begin
            $display("the bound checker raised %0d assertion errors", dut_i.chk_i.fail_count);
            errors++;
        end
    endtask

    // quiet means no load pulse for 20 word times
    task automatic wait_quiet();
        int start;
        start = cycle;
        do
            @(negedge clk);
        while (cycle - ((last_load > start) ? last_load : start) < quiet_cycles);
    endtask

    task automatic press(input logic left, input int hold);
        if (left)
            btnl = 1'b1;
        else
            btnr = 1'b1;
        repeat (hold) @(negedge clk);
        btnl = 1'b0;
        btnr = 1'b0;
        repeat (hold) @(negedge clk);
        model = left ? model + 1 : model - 1;
    endtask

    task automatic end_test(input string name, input int err0);
        tests_run++;
        if (errors == err0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err0);
        end
    endtask

    initial begin
        int   err0;
        int   base;
        logic left;
        reset = 1'b1;
        btnl  = 1'b0;
        btnr  = 1'b0;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        err0 = errors;
        check_val("led", 32'(led), 32'h3f);
        check_val("max7219_clk", 32'(max7219_clk), 0);
        check_val("max7219_data", 32'(max7219_data), 0);
        check_val("max7219_load", 32'(max7219_load), 0);
        wait_quiet();
        check_words(0, 0, 5);
        end_test("1 init words", err0);

        err0 = errors;
        check_words(0, 5, 13);
        check_val("decoded word count", word_log.size(), 13);
        check_display(model);
        end_test("2 digits after reset", err0);

        err0 = errors;
        for (int i = 0; i < 10; i++) begin
            left = (i < 2) ? 1'b0 : (random_bits(1) != 0);  // start below zero
            press(left, 16 + random_bits(4));
            wait_quiet();
            check_display(model);
        end
        end_test("3 random presses", err0);

        err0 = errors;
        for (int i = 0; i < 6; i++) begin
            if (random_bits(1) != 0)
                btnl = 1'b1;
            else
                btnr = 1'b1;
            repeat (1 + random_bits(2)) @(negedge clk);  // below debounce time
            btnl = 1'b0;
            btnr = 1'b0;
            repeat (16) @(negedge clk);
        end
        btnl = 1'b1;
        btnr = 1'b1;
        repeat (16 + random_bits(4)) @(negedge clk);
        btnl = 1'b0;
        btnr = 1'b0;
        repeat (16) @(negedge clk);
        wait_quiet();
        check_display(model);
        end_test("4 glitches and both buttons", err0);

        err0 = errors;
        base = word_log.size();
        for (int i = 0; i < 10; i++)
            press(random_bits(1) != 0, 16);
        wait_quiet();
        check_display(model);
        for (int i = base; i < word_log.size(); i++)
            check_val($sformatf("address of word %0d", i), 32'(word_log[i][11:8]),
                      1 + (i - base) % 8);
        check_val("digit words mod 8", (word_log.size() - base) % 8, 0);
        check_checker();
        end_test("5 press burst", err0);

        err0 = errors;
        press(1'b1, 16);
        while (!max7219_clk)
            @(negedge clk);  // a word is now on the wire
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        model = '0;
        base = word_log.size();
        wait_quiet();
        check_words(base, 0, 13);
        check_display(model);
        check_checker();
        end_test("6 reset mid-frame", err0);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

/* word_fifo.sv */
`timescale 1ns/10ps

module word_fifo import board_pkg::*; #(
    parameter int fifo_depth = 16
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wr_en,
    input  logic [cmd_width-1:0] wr_data,
    input  logic                 rd_en,
    output logic [cmd_width-1:0] rd_data,
    output logic                 full,
    output logic                 empty
);

    localparam int aw = $clog2(fifo_depth);
    localparam int cw = $clog2(fifo_depth + 1);
    localparam logic [aw-1:0] last_ptr = aw'(fifo_depth - 1);

    logic [cmd_width-1:0] mem [fifo_depth];
    logic [aw-1:0]        wr_ptr;
    logic [aw-1:0]        rd_ptr;
    logic [cw-1:0]        count;
    logic                 do_wr;
    logic                 do_rd;

    assign full  = (count == cw'(fifo_depth));
    assign empty = (count == '0);
    assign do_wr = wr_en && !full;   // overflow is dropped
    assign do_rd = rd_en && !empty;

    assign rd_data = mem[rd_ptr];    // show-ahead

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
            if (do_wr && !do_rd)
                count <= count + 1'b1;
            else if (do_rd && !do_wr)
                count <= count - 1'b1;
        end
    end

endmodule
